//--- mult_pkg.sv
package mult_pkg;

    // datapath widths
    localparam int XLEN = 32;
    typedef logic [XLEN-1:0] data_t;

    // two extra bits so signed and unsigned operands share one signed multiplier
    localparam int PP_WIDTH = XLEN + 2;
    localparam int NUM_PP = PP_WIDTH / 2;
    localparam int ROW_WIDTH = 2 * PP_WIDTH;
    typedef logic [ROW_WIDTH-1:0] row_t;

    // operation codes
    typedef logic [1:0] mult_op_t;
    localparam mult_op_t MULT_MUL = 2'd0;
    localparam mult_op_t MULT_MULH = 2'd1;
    localparam mult_op_t MULT_MULHSU = 2'd2;
    localparam mult_op_t MULT_MULHU = 2'd3;

    // reorder buffer index, msb is the wrap flag
    localparam int ROB_WIDTH = 6;
    typedef logic [ROB_WIDTH-1:0] rob_idx_t;

    localparam int PREG_WIDTH = 6;
    typedef logic [PREG_WIDTH-1:0] preg_t;

    // register block address map
    localparam int AXIL_ADDR_W = 4;
    localparam logic [AXIL_ADDR_W-1:0] CSR_CTRL = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] CSR_RETIRED = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] CSR_CANCELLED = 4'h8;
    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // true when a was allocated after b in the circular reorder buffer
    function automatic logic rob_younger(rob_idx_t a, rob_idx_t b);
        if (a[ROB_WIDTH-1] == b[ROB_WIDTH-1]) begin
            return a[ROB_WIDTH-2:0] > b[ROB_WIDTH-2:0];
        end
        return a[ROB_WIDTH-2:0] < b[ROB_WIDTH-2:0];
    endfunction

endpackage

//--- mult_if.sv
interface mult_issue_if;
    import mult_pkg::*;

    logic valid;
    logic ready;
    mult_op_t op;
    data_t rs1;
    data_t rs2;
    preg_t rd;
    logic we;
    rob_idx_t rob_idx;

    modport master (output valid, op, rs1, rs2, rd, we, rob_idx, input ready);
    modport slave (input valid, op, rs1, rs2, rd, we, rob_idx, output ready);
endinterface

interface mult_wb_if;
    import mult_pkg::*;

    // no ready, writeback always takes the result
    logic valid;
    preg_t rd;
    logic we;
    rob_idx_t rob_idx;
    data_t res;

    modport source (output valid, rd, we, rob_idx, res);
    modport sink (input valid, rd, we, rob_idx, res);
endinterface

//--- axil_if.sv
interface axil_if;
    import mult_pkg::*;

    logic [AXIL_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    data_t wdata;
    logic [XLEN/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    data_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );
    modport slave (
        input awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );
endinterface

//--- booth_pp_gen.sv
module booth_pp_gen (
    input logic [mult_pkg::PP_WIDTH-1:0] multiplicand,
    input logic [mult_pkg::PP_WIDTH-1:0] multiplier,
    output mult_pkg::row_t rows [mult_pkg::NUM_PP]
);
    import mult_pkg::*;

    // multiplier with the implicit zero below bit 0
    logic [PP_WIDTH:0] mult_ext;
    logic [PP_WIDTH-1:0] mcand_x2;
    logic [NUM_PP-1:0] sel_one;
    logic [NUM_PP-1:0] sel_two;
    logic [NUM_PP-1:0] neg;
    logic [PP_WIDTH-1:0] pp [NUM_PP];
    row_t pp_ext [NUM_PP];

    assign mult_ext = {multiplier, 1'b0};
    assign mcand_x2 = {multiplicand[PP_WIDTH-2:0], 1'b0};

    for (genvar i = 0; i < NUM_PP; i++) begin : g_digit
        logic [2:0] y;

        // overlapping triplet y[i+1], y[i], y[i-1]
        assign y = mult_ext[2*i +: 3];

        // digit magnitude one, magnitude two, and sign
        assign sel_one[i] = y[0] ^ y[1];
        assign sel_two[i] = (y[1] & y[0] & ~y[2]) | (~y[1] & ~y[0] & y[2]);
        assign neg[i] = y[2] & ~(y[1] & y[0]);

        // negative digits give the one's complement here, the +1 goes in the next row
        assign pp[i] = {PP_WIDTH{neg[i]}} ^
                       (({PP_WIDTH{sel_one[i]}} & multiplicand) |
                        ({PP_WIDTH{sel_two[i]}} & mcand_x2));

        assign pp_ext[i] = {{(ROW_WIDTH-PP_WIDTH){pp[i][PP_WIDTH-1]}}, pp[i]};

        if (i == 0) begin : g_first
            assign rows[i] = pp_ext[i];
        end else begin : g_next
            // row i weighs 4^i, the previous row's correction sits at bit 2i-2
            assign rows[i] = (pp_ext[i] << (2 * i)) |
                             (row_t'(neg[i-1]) << (2 * i - 2));
        end
    end

    // the top digit is never negative because of the two extension bits,
    // so no correction row is needed after the last one

endmodule

//--- csa_tree.sv
module csa_tree (
    input logic clk,
    input mult_pkg::row_t rows [mult_pkg::NUM_PP],
    output mult_pkg::row_t sum_row,
    output mult_pkg::row_t carry_row
);
    import mult_pkg::*;

    typedef row_t level_t [NUM_PP];

    level_t lvl1;
    level_t lvl2;
    level_t stage1_q;
    level_t lvl3;
    level_t lvl4;
    level_t lvl5;
    level_t stage2_q;
    level_t lvl6;

    // live row count after a number of 3:2 levels, 17 12 8 6 4 3 2
    function automatic int rows_after(int levels);
        int n;
        n = NUM_PP;
        for (int l = 0; l < levels; l++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    // one level of 3:2 compressors over the first n rows, leftovers pass through
    function automatic level_t reduce_level(level_t a, int n);
        level_t r;
        int m;
        r = '{default: '0};
        m = n / 3;
        for (int k = 0; k < NUM_PP / 3; k++) begin
            if (k < m) begin
                r[2*k] = a[3*k] ^ a[3*k+1] ^ a[3*k+2];
                // carry out of the top bit falls off, result is mod 2^ROW_WIDTH
                r[2*k+1] = ((a[3*k] & a[3*k+1]) |
                            (a[3*k] & a[3*k+2]) |
                            (a[3*k+1] & a[3*k+2])) << 1;
            end
        end
        for (int k = 0; k < NUM_PP; k++) begin
            if (k >= 3 * m && k < n) begin
                r[k-m] = a[k];
            end
        end
        return r;
    endfunction

    // levels 1 and 2 in the issue cycle
    always_comb begin
        lvl1 = reduce_level(rows, rows_after(0));
        lvl2 = reduce_level(lvl1, rows_after(1));
    end

    // levels 3 to 5 in the middle cycle
    always_comb begin
        lvl3 = reduce_level(stage1_q, rows_after(2));
        lvl4 = reduce_level(lvl3, rows_after(3));
        lvl5 = reduce_level(lvl4, rows_after(4));
    end

    // last level feeds the final adder in the writeback cycle
    always_comb begin
        lvl6 = reduce_level(stage2_q, rows_after(5));
    end

    always_ff @(posedge clk) begin
        stage1_q <= lvl2;
        stage2_q <= lvl5;
    end

    assign sum_row = lvl6[0];
    assign carry_row = lvl6[1];

endmodule

//--- mult_unit.sv
module mult_unit (
    input logic clk,
    input logic reset,
    mult_issue_if.slave issue,
    mult_wb_if.source wb,
    input logic enable,
    input logic redirect,
    input mult_pkg::rob_idx_t redirect_idx,
    output logic wakeup_valid,
    output logic wakeup_we,
    output mult_pkg::preg_t wakeup_rd,
    output logic retire_pulse,
    output logic cancel_pulse
);
    import mult_pkg::*;

    logic fire;
    logic sext1;
    logic sext2;
    logic sel_high;
    logic [PP_WIDTH-1:0] opa;
    logic [PP_WIDTH-1:0] opb;
    row_t rows [NUM_PP];
    row_t sum_row;
    row_t carry_row;
    row_t product;

    logic s1_valid;
    logic s1_sel_high;
    preg_t s1_rd;
    logic s1_we;
    rob_idx_t s1_rob_idx;

    logic s2_valid;
    logic s2_sel_high;
    preg_t s2_rd;
    logic s2_we;
    rob_idx_t s2_rob_idx;

    logic flushed;

    assign issue.ready = enable;
    assign fire = issue.valid & issue.ready;

    // rs1 is signed except for MULHU, rs2 only for MUL and MULH
    assign sext1 = issue.op != MULT_MULHU;
    assign sext2 = (issue.op == MULT_MUL) || (issue.op == MULT_MULH);
    assign sel_high = issue.op != MULT_MUL;

    assign opa = {{2{sext1 & issue.rs1[XLEN-1]}}, issue.rs1};
    assign opb = {{2{sext2 & issue.rs2[XLEN-1]}}, issue.rs2};

    // consumers can be scheduled as soon as the op is accepted
    assign wakeup_valid = fire;
    assign wakeup_we = issue.we;
    assign wakeup_rd = issue.rd;

    booth_pp_gen pp_gen_i (
        .multiplicand (opa),
        .multiplier   (opb),
        .rows         (rows)
    );

    csa_tree tree_i (
        .clk       (clk),
        .rows      (rows),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    // control follows the tree registers stage for stage
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= fire;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sel_high <= sel_high;
        s1_rd <= issue.rd;
        s1_we <= issue.we;
        s1_rob_idx <= issue.rob_idx;
        s2_sel_high <= s1_sel_high;
        s2_rd <= s1_rd;
        s2_we <= s1_we;
        s2_rob_idx <= s1_rob_idx;
    end

    assign product = sum_row + carry_row;

    // only results on the wrong path of this cycle's redirect are dropped
    assign flushed = redirect & rob_younger(s2_rob_idx, redirect_idx);

    assign wb.valid = s2_valid & ~flushed;
    assign wb.rd = s2_rd;
    assign wb.we = s2_we;
    assign wb.rob_idx = s2_rob_idx;
    assign wb.res = s2_sel_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    assign retire_pulse = wb.valid;
    assign cancel_pulse = s2_valid & flushed;

endmodule

//--- mult_csr.sv
module mult_csr (
    input logic clk,
    input logic reset,
    axil_if.slave bus,
    output logic enable,
    input logic retire_pulse,
    input logic cancel_pulse
);
    import mult_pkg::*;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic aw_pend;
    logic w_pend;
    logic wr_fire;
    logic [AXIL_ADDR_W-1:0] aw_addr_q;
    data_t w_data_q;
    logic [XLEN/8-1:0] w_strb_q;
    logic [AXIL_ADDR_W-1:0] wr_addr;
    data_t wr_data;
    logic [XLEN/8-1:0] wr_strb;
    data_t retired_cnt;
    data_t cancelled_cnt;

    // each channel takes one beat, then waits for its partner
    assign bus.awready = ~bus.bvalid & ~aw_pend;
    assign bus.wready = ~bus.bvalid & ~w_pend;
    assign bus.arready = ~bus.rvalid;
    assign bus.bresp = AXIL_RESP_OKAY;
    assign bus.rresp = AXIL_RESP_OKAY;

    assign aw_hs = bus.awvalid & bus.awready;
    assign w_hs = bus.wvalid & bus.wready;
    assign ar_hs = bus.arvalid & bus.arready;

    assign wr_fire = (aw_pend | aw_hs) & (w_pend | w_hs);
    assign wr_addr = aw_pend ? aw_addr_q : bus.awaddr;
    assign wr_data = w_pend ? w_data_q : bus.wdata;
    assign wr_strb = w_pend ? w_strb_q : bus.wstrb;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= bus.awaddr;
        end
        if (w_hs) begin
            w_data_q <= bus.wdata;
            w_strb_q <= bus.wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_pend <= 1'b0;
            w_pend <= 1'b0;
            bus.bvalid <= 1'b0;
        end else begin
            aw_pend <= ~wr_fire & (aw_pend | aw_hs);
            w_pend <= ~wr_fire & (w_pend | w_hs);
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
        end
    end

    // a write to a counter clears it even if an event lands in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b1;
            retired_cnt <= '0;
            cancelled_cnt <= '0;
        end else begin
            if (wr_fire && wr_addr == CSR_CTRL && wr_strb[0]) begin
                enable <= wr_data[0];
            end
            if (wr_fire && wr_addr == CSR_RETIRED) begin
                retired_cnt <= '0;
            end else if (retire_pulse) begin
                retired_cnt <= retired_cnt + 1'b1;
            end
            if (wr_fire && wr_addr == CSR_CANCELLED) begin
                cancelled_cnt <= '0;
            end else if (cancel_pulse) begin
                cancelled_cnt <= cancelled_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rvalid <= 1'b0;
        end else if (ar_hs) begin
            bus.rvalid <= 1'b1;
        end else if (bus.rready) begin
            bus.rvalid <= 1'b0;
        end
    end

    // read data is sampled at address acceptance and held with rvalid
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (bus.araddr)
                CSR_CTRL: bus.rdata <= {{(XLEN-1){1'b0}}, enable};
                CSR_RETIRED: bus.rdata <= retired_cnt;
                CSR_CANCELLED: bus.rdata <= cancelled_cnt;
                default: bus.rdata <= '0;
            endcase
        end
    end

endmodule

//--- mult_top.sv
module mult_top (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    output logic issue_ready,
    input mult_pkg::mult_op_t issue_op,
    input mult_pkg::data_t issue_rs1,
    input mult_pkg::data_t issue_rs2,
    input mult_pkg::preg_t issue_rd,
    input logic issue_we,
    input mult_pkg::rob_idx_t issue_rob_idx,
    output logic wb_valid,
    output mult_pkg::preg_t wb_rd,
    output logic wb_we,
    output mult_pkg::rob_idx_t wb_rob_idx,
    output mult_pkg::data_t wb_res,
    output logic wakeup_valid,
    output logic wakeup_we,
    output mult_pkg::preg_t wakeup_rd,
    input logic redirect,
    input mult_pkg::rob_idx_t redirect_idx,
    input logic [mult_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
    input logic s_axil_awvalid,
    output logic s_axil_awready,
    input mult_pkg::data_t s_axil_wdata,
    input logic [mult_pkg::XLEN/8-1:0] s_axil_wstrb,
    input logic s_axil_wvalid,
    output logic s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic s_axil_bvalid,
    input logic s_axil_bready,
    input logic [mult_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
    input logic s_axil_arvalid,
    output logic s_axil_arready,
    output mult_pkg::data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic s_axil_rvalid,
    input logic s_axil_rready
);
    logic enable;
    logic retire_pulse;
    logic cancel_pulse;

    mult_issue_if issue_bus ();
    mult_wb_if wb_bus ();
    axil_if axil_bus ();

    assign issue_bus.valid = issue_valid;
    assign issue_bus.op = issue_op;
    assign issue_bus.rs1 = issue_rs1;
    assign issue_bus.rs2 = issue_rs2;
    assign issue_bus.rd = issue_rd;
    assign issue_bus.we = issue_we;
    assign issue_bus.rob_idx = issue_rob_idx;
    assign issue_ready = issue_bus.ready;

    assign wb_valid = wb_bus.valid;
    assign wb_rd = wb_bus.rd;
    assign wb_we = wb_bus.we;
    assign wb_rob_idx = wb_bus.rob_idx;
    assign wb_res = wb_bus.res;

    // the outside world is the bus master
    assign axil_bus.awaddr = s_axil_awaddr;
    assign axil_bus.awvalid = s_axil_awvalid;
    assign axil_bus.wdata = s_axil_wdata;
    assign axil_bus.wstrb = s_axil_wstrb;
    assign axil_bus.wvalid = s_axil_wvalid;
    assign axil_bus.bready = s_axil_bready;
    assign axil_bus.araddr = s_axil_araddr;
    assign axil_bus.arvalid = s_axil_arvalid;
    assign axil_bus.rready = s_axil_rready;
    assign s_axil_awready = axil_bus.awready;
    assign s_axil_wready = axil_bus.wready;
    assign s_axil_bresp = axil_bus.bresp;
    assign s_axil_bvalid = axil_bus.bvalid;
    assign s_axil_arready = axil_bus.arready;
    assign s_axil_rdata = axil_bus.rdata;
    assign s_axil_rresp = axil_bus.rresp;
    assign s_axil_rvalid = axil_bus.rvalid;

    mult_unit unit_i (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue_bus.slave),
        .wb           (wb_bus.source),
        .enable       (enable),
        .redirect     (redirect),
        .redirect_idx (redirect_idx),
        .wakeup_valid (wakeup_valid),
        .wakeup_we    (wakeup_we),
        .wakeup_rd    (wakeup_rd),
        .retire_pulse (retire_pulse),
        .cancel_pulse (cancel_pulse)
    );

    mult_csr csr_i (
        .clk          (clk),
        .reset        (reset),
        .bus          (axil_bus.slave),
        .enable       (enable),
        .retire_pulse (retire_pulse),
        .cancel_pulse (cancel_pulse)
    );

endmodule

//--- tb_mult_assertions.sv
module tb_mult_assertions (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input logic issue_ready,
    input logic wb_valid,
    input logic s_axil_bvalid,
    input logic s_axil_bready,
    input logic s_axil_rvalid,
    input logic s_axil_rready,
    input mult_pkg::data_t s_axil_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of assertion failures
    int fail_count = 0;

    // every result goes back to an accepted issue exactly two cycles before
    wb_latency: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> $past(issue_valid && issue_ready, 2))
    else begin
        $error("wb_valid without an accepted issue two cycles earlier");
        fail_count++;
    end

    bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        fail_count++;
    end

endmodule

bind mult_top tb_mult_assertions assert_i (.*);

//--- tb_mult_top.sv
module tb_mult_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mult_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ISSUES = 2000;
    // random phase runs about three issues per four cycles, the rest is AXI traffic and margin
    localparam int MAX_CYCLES = NUM_ISSUES * 2 + 500;

    typedef struct {
        int cycle;
        data_t res;
        preg_t rd;
        logic we;
        rob_idx_t rob_idx;
    } expect_t;

    logic clk;
    logic reset;
    logic issue_valid;
    logic issue_ready;
    mult_op_t issue_op;
    data_t issue_rs1;
    data_t issue_rs2;
    preg_t issue_rd;
    logic issue_we;
    rob_idx_t issue_rob_idx;
    logic wb_valid;
    preg_t wb_rd;
    logic wb_we;
    rob_idx_t wb_rob_idx;
    data_t wb_res;
    logic wakeup_valid;
    logic wakeup_we;
    preg_t wakeup_rd;
    logic redirect;
    rob_idx_t redirect_idx;
    logic [AXIL_ADDR_W-1:0] s_axil_awaddr;
    logic s_axil_awvalid;
    logic s_axil_awready;
    data_t s_axil_wdata;
    logic [XLEN/8-1:0] s_axil_wstrb;
    logic s_axil_wvalid;
    logic s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic s_axil_bvalid;
    logic s_axil_bready;
    logic [AXIL_ADDR_W-1:0] s_axil_araddr;
    logic s_axil_arvalid;
    logic s_axil_arready;
    data_t s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic s_axil_rvalid;
    logic s_axil_rready;

    logic [31:0] lfsr = 32'hb2964368;
    expect_t model_q [$];
    expect_t head;
    logic exp_valid;
    logic exp_enable;
    logic accepted;
    int cycle_count = 0;
    int retired_count = 0;
    int cancelled_count = 0;
    int issued;
    int retired_before;
    data_t rd_data;

    mult_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // mostly random, with the corner values mixed in
    function automatic data_t pick_operand();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd5: return '0;
            3'd6: return '1;
            3'd7: return 32'h8000_0000;
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic data_t expected_result(mult_op_t op, data_t rs1, data_t rs2);
        longint a;
        longint b;
        logic [63:0] prod;
        case (op)
            MULT_MUL, MULT_MULH: begin
                a = longint'($signed(rs1));
                b = longint'($signed(rs2));
            end
            MULT_MULHSU: begin
                a = longint'($signed(rs1));
                b = longint'({32'h0, rs2});
            end
            default: begin
                a = longint'({32'h0, rs1});
                b = longint'({32'h0, rs2});
            end
        endcase
        prod = a * b;
        return (op == MULT_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    // same wrap flag compares slots directly, a flipped flag reverses the order
    function automatic logic is_younger(rob_idx_t a, rob_idx_t b);
        if (a[5] == b[5]) begin
            return a[4:0] > b[4:0];
        end
        return a[4:0] < b[4:0];
    endfunction

    task automatic check_val(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch at %0t ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_random_issue();
        issue_valid = 1'b1;
        issue_op = mult_op_t'(rand_bits(2));
        issue_rs1 = pick_operand();
        issue_rs2 = pick_operand();
        issue_rd = preg_t'(rand_bits(6));
        issue_we = rand_bits(1) != 0;
        issue_rob_idx = rob_idx_t'(rand_bits(6));
    endtask

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input data_t data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        next_edge();
        s_axil_awaddr = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata = data;
        s_axil_wstrb = '1;
        s_axil_wvalid = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (s_axil_awvalid && s_axil_awready) aw_done = 1'b1;
            if (s_axil_wvalid && s_axil_wready) w_done = 1'b1;
            next_edge();
            s_axil_awvalid = s_axil_awvalid & ~aw_done;
            s_axil_wvalid = s_axil_wvalid & ~w_done;
        end
        // the enable bit changes on the edge that completed the write
        if (addr == CSR_CTRL) begin
            exp_enable = data[0];
        end
        // response is due right after the edge that took the second beat
        check_val("s_axil_bvalid", 1, s_axil_bvalid);
        check_val("s_axil_bresp", AXIL_RESP_OKAY, s_axil_bresp);
        next_edge();
        s_axil_bready = 1'b1;
        next_edge();
        s_axil_bready = 1'b0;
        check_val("s_axil_bvalid", 0, s_axil_bvalid);
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output data_t data);
        logic ar_done;
        ar_done = 1'b0;
        next_edge();
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        while (!ar_done) begin
            @(negedge clk);
            ar_done = s_axil_arready;
            next_edge();
            s_axil_arvalid = s_axil_arvalid & ~ar_done;
        end
        check_val("s_axil_rvalid", 1, s_axil_rvalid);
        check_val("s_axil_rresp", AXIL_RESP_OKAY, s_axil_rresp);
        // hold rready low one cycle so the data has to stay put
        next_edge();
        data = s_axil_rdata;
        s_axil_rready = 1'b1;
        next_edge();
        s_axil_rready = 1'b0;
        check_val("s_axil_rvalid", 0, s_axil_rvalid);
    endtask

    // reference model, sampled mid cycle when every input has settled
    always @(negedge clk) begin
        if (!reset) begin
            cycle_count++;
            exp_valid = 1'b0;
            if (model_q.size() > 0 && model_q[0].cycle == cycle_count - 2) begin
                head = model_q.pop_front();
                exp_valid = !(redirect && is_younger(head.rob_idx, redirect_idx));
                if (exp_valid) begin
                    retired_count++;
                end else begin
                    cancelled_count++;
                end
            end
            check_val("wb_valid", exp_valid, wb_valid);
            if (exp_valid) begin
                check_val("wb_res", head.res, wb_res);
                check_val("wb_rd", head.rd, wb_rd);
                check_val("wb_we", head.we, wb_we);
                check_val("wb_rob_idx", head.rob_idx, wb_rob_idx);
            end
            check_val("issue_ready", exp_enable, issue_ready);
            accepted = issue_valid & exp_enable;
            check_val("wakeup_valid", accepted, wakeup_valid);
            if (accepted) begin
                check_val("wakeup_rd", issue_rd, wakeup_rd);
                check_val("wakeup_we", issue_we, wakeup_we);
                model_q.push_back('{cycle_count,
                                    expected_result(issue_op, issue_rs1, issue_rs2),
                                    issue_rd, issue_we, issue_rob_idx});
            end
        end
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // any failed bound assertion ends the run at once
    initial begin
        wait (dut_i.assert_i.fail_count != 0);
        $display("a bound assertion failed at %0t ns", $time);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        exp_enable = 1'b1;
        issue_valid = 1'b0;
        issue_op = MULT_MUL;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_rd = '0;
        issue_we = 1'b0;
        issue_rob_idx = '0;
        redirect = 1'b0;
        redirect_idx = '0;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        next_edge();
        check_val("wb_valid", 0, wb_valid);
        check_val("issue_ready", 1, issue_ready);
        axil_read(CSR_RETIRED, rd_data);
        check_val("RETIRED", 0, rd_data);
        axil_read(CSR_CANCELLED, rd_data);
        check_val("CANCELLED", 0, rd_data);

        // random issues with gaps and random redirects
        issued = 0;
        while (issued < NUM_ISSUES) begin
            next_edge();
            if (rand_bits(2) != 0) begin
                drive_random_issue();
                issued++;
            end else begin
                issue_valid = 1'b0;
            end
            redirect = rand_bits(2) == 0;
            redirect_idx = rob_idx_t'(rand_bits(6));
        end
        next_edge();
        issue_valid = 1'b0;
        redirect = 1'b0;
        repeat (3) next_edge();

        // disabled unit must ignore issue_valid
        axil_write(CSR_CTRL, 32'h0);
        next_edge();
        check_val("issue_ready", 0, issue_ready);
        repeat (4) begin
            drive_random_issue();
            next_edge();
        end
        issue_valid = 1'b0;
        repeat (3) next_edge();
        axil_read(CSR_CTRL, rd_data);
        check_val("CTRL", 0, rd_data);

        axil_write(CSR_CTRL, 32'h1);
        next_edge();
        check_val("issue_ready", 1, issue_ready);
        retired_before = retired_count;
        repeat (20) begin
            next_edge();
            drive_random_issue();
        end
        next_edge();
        issue_valid = 1'b0;
        repeat (3) next_edge();
        check_val("results after enable", 20, retired_count - retired_before);

        axil_read(CSR_RETIRED, rd_data);
        check_val("RETIRED", retired_count, rd_data);
        axil_read(CSR_CANCELLED, rd_data);
        check_val("CANCELLED", cancelled_count, rd_data);
        axil_write(CSR_RETIRED, 32'hffff_ffff);
        axil_read(CSR_RETIRED, rd_data);
        check_val("RETIRED", 0, rd_data);
        axil_write(CSR_CANCELLED, 32'h1234_5678);
        axil_read(CSR_CANCELLED, rd_data);
        check_val("CANCELLED", 0, rd_data);

        next_edge();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- list.f
mult_pkg.sv
mult_if.sv
axil_if.sv
booth_pp_gen.sv
csa_tree.sv
mult_unit.sv
mult_csr.sv
mult_top.sv
tb_mult_assertions.sv
tb_mult_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mult_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
